// File: build.f
+incdir+include
logic/frame_app_pkg.sv
logic/msg_fifo.sv
logic/host_msg_splitter.sv
logic/pixel_timing.sv
logic/coeff_dram_ctrl.sv
logic/frame_app_top.sv
tb/dram_model.sv
tb/frame_app_tb.sv

// File: Makefile
# Verilator build for the frame application testbench
VERILATOR ?= verilator
TOP       ?= frame_app_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# simulator exit status carries pass or fail
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tb/frame_app_tb.sv
`timescale 1ns/1ps
`include "frame_app_macros.svh"

module frame_app_tb;
  localparam int TEST_CYCLES    = 1500;  // upper bound for all six tests with DRAM stalls
  localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;
  localparam int N_COEF         = 32;    // two runs of 16 words, eight DRAM lines
  localparam int N_BEATS        = N_COEF / 2;

  logic                CLK = 1'b0;
  logic                fds_val;
  logic                pc_msg_pending, pc_msg_ack;
  logic [`XB_W-1:0]    pc_msg;
  logic                app_en, dram_read, app_rdy;
  logic [`ADDR_W-1:0]  app_addr;
  logic                app_wdf_wren, app_wdf_end, app_wdf_rdy, app_rd_data_valid;
  logic [`APP_W-1:0]   app_wdf_data, app_rd_data, fpga_msg;
  logic                fpga_msg_valid, fpga_msg_full;
  logic [`ROW_W-1:0]   n_row;
  logic [`COL_W-1:0]   l_col;
  logic [`FRAME_W-1:0] n_frame;
  logic                error;
  logic [3:0]          gpio_led;

  integer            seed = 95;
  int                cycles = 0;
  logic [`XB_W-1:0]  coef [N_COEF];  // every coefficient word sent in order
  logic [`APP_W-1:0] rx_q [$];       // beats seen on the FPGA message port

  frame_app_top u_dut (.*);
  dram_model    u_dram (.*);

  always #2 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation stopped on timeout");
    end
  end

  // FPGA port capture plus checks that hold on every cycle
  always @(posedge CLK) begin
    if (!fds_val) begin
      if (fpga_msg_valid) rx_q.push_back(fpga_msg);
      check_eq(64'(app_en && dram_read && fpga_msg_full), 64'd0, "read command while full");
      check_eq(64'(error), 64'd0, "error output");
    end
  end

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic send_word(input logic [`XB_W-1:0] w);
    pc_msg         = w;
    pc_msg_pending = 1'b1;
    do @(posedge CLK); while (!pc_msg_ack);  // word moves on the edge that sees ack
    #1 pc_msg_pending = 1'b0;
  endtask

  task automatic send_pixel(input logic fv, input logic lv);
    logic [`XB_W-1:0] r;
    r = $random(seed);
    send_word({r[`XB_W-1:6], fv, lv, 4'h0});  // low bits 00 mark a pixel word
  endtask

  task automatic send_frame(input int lines, input int words);
    send_pixel(1'b0, 1'b0);                 // frame-valid low first
    for (int l = 0; l < lines; l++) begin
      if (l > 0) send_pixel(1'b1, 1'b0);   // gap between lines
      for (int i = 0; i < words; i++) send_pixel(1'b1, 1'b1);
    end
    send_pixel(1'b0, 1'b0);                 // line and frame end together
  endtask

  task automatic drain_pixels();
    @(posedge CLK);  // FIFO write of the last word
    do @(posedge CLK); while (!u_dut.u_pix_fifo.empty);
    #1;
  endtask

  task automatic send_coef(input int first, input int count);
    logic [`XB_W-1:0] w;
    for (int i = first; i < first + count; i++) begin
      w = $random(seed);
      // run start must not look like a pixel word
      // line ends must not look like the end marker
      if (i % 16 == 0 || i % 4 == 3) w[1] = 1'b1;
      if (i == N_COEF - 1) w[1:0] = 2'b01;  // end marker on the last line
      coef[i] = w;
      send_word(w);
    end
  endtask

  // beat j of the table with host words packed low word first
  function automatic logic [`APP_W-1:0] line_beat(input int j);
    int k;
    k = j / 2;
    if (j % 2 == 0) return {coef[4*k+1], coef[4*k]};
    return {coef[4*k+3], coef[4*k+2]};
  endfunction

  task automatic check_writes(input int first, input int last);
    for (int k = first; k <= last; k++) begin
      check_eq(64'(u_dram.wr_addr_log[k]), 64'(k * `ADDR_STEP), "burst address");
      check_eq(u_dram.wr_lo_log[k], line_beat(2 * k), "burst first beat");
      check_eq(u_dram.wr_hi_log[k], line_beat(2 * k + 1), "burst second beat");
    end
  endtask

  task automatic check_readback(input int base);
    check_eq(64'(rx_q.size() - base), 64'(N_BEATS), "read-back beat count");
    for (int j = 0; j < N_BEATS; j++) check_eq(rx_q[base + j], line_beat(j), "read-back beat");
  endtask

  task automatic test_reset();
    check_eq(64'(pc_msg_ack), 64'd0, "pc_msg_ack after reset");
    check_eq(64'(app_en), 64'd0, "app_en after reset");
    check_eq(64'(dram_read), 64'd0, "dram_read after reset");
    check_eq(64'(app_wdf_wren), 64'd0, "app_wdf_wren after reset");
    check_eq(64'(app_wdf_end), 64'd1, "app_wdf_end after reset");
    check_eq(64'(fpga_msg_valid), 64'd0, "fpga_msg_valid after reset");
    check_eq(64'(error), 64'd0, "error after reset");
    // LEDs show the loader state on top of the error bit
    check_eq(64'(gpio_led), 64'({frame_app_pkg::LD_MSG_WAIT, 1'b0}),
             "gpio_led after reset");
  endtask

  task automatic test_pixels();
    send_frame(3, 5);
    drain_pixels();
    check_eq(64'(l_col), 64'd10, "l_col");  // 5 words of 2 pixels
    check_eq(64'(n_row), 64'd2, "n_row");
    check_eq(64'(n_frame), 64'd1, "n_frame");
  endtask

  task automatic test_coef_writes();
    send_coef(0, 16);
    while (u_dram.wr_count < 4) @(posedge CLK);
    #1;
    check_eq(64'(u_dram.wr_count), 64'd4, "DRAM burst count");
    check_writes(0, 3);
  endtask

  task automatic test_readback();
    int base;
    base = rx_q.size();
    send_coef(16, 16);
    while (rx_q.size() < base + N_BEATS) @(posedge CLK);
    #1;
    check_eq(64'(u_dram.wr_count), 64'd8, "DRAM burst count");
    check_writes(4, 7);
    check_readback(base);
    // table fully read, loader waits for the next frame
    check_eq(64'(gpio_led), 64'({frame_app_pkg::LD_INTERFRAME, 1'b0}),
             "gpio_led after read-back");
  endtask

  task automatic test_backpressure();
    int base;
    base          = rx_q.size();
    fpga_msg_full = 1'b1;
    send_frame(1, 4);           // frame start arms the replay while the port is full
    repeat (8) @(posedge CLK);
    #1;
    check_eq(64'(rx_q.size() - base), 64'd0, "beats while held full");
    check_eq(64'(gpio_led), 64'({frame_app_pkg::LD_THROTTLED, 1'b0}),
             "gpio_led while held full");
    while (rx_q.size() < base + N_BEATS) begin
      fpga_msg_full = ($random(seed) % 2) != 0;  // full on about half the cycles
      @(posedge CLK);
      #1;
    end
    fpga_msg_full = 1'b0;
    check_readback(base);
  endtask

  task automatic test_replay();
    int base;
    base = rx_q.size();
    send_frame(2, 3);
    while (rx_q.size() < base + N_BEATS) @(posedge CLK);
    repeat (40) @(posedge CLK);  // a second replay would start in here
    #1;
    check_readback(base);
    drain_pixels();
    check_eq(64'(n_frame), 64'd3, "n_frame after replay");
    check_eq(64'(error), 64'd0, "error at end");
  endtask

  initial begin
    fds_val        = 1'b1;
    pc_msg_pending = 1'b0;
    pc_msg         = '0;
    fpga_msg_full  = 1'b0;
    repeat (3) @(posedge CLK);
    #1 fds_val = 1'b0;
    test_reset();
    test_pixels();
    test_coef_writes();
    test_readback();
    test_backpressure();
    test_replay();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: tb/dram_model.sv
`timescale 1ns/1ps
`include "frame_app_macros.svh"

// DRAM stand-in with random command and write-data stalls and a fixed read latency
module dram_model (
  input  logic               CLK,
  input  logic               fds_val,
  input  logic               app_en,
  input  logic               dram_read,
  input  logic [`ADDR_W-1:0] app_addr,
  output logic               app_rdy,
  input  logic               app_wdf_wren,
  input  logic               app_wdf_end,
  input  logic [`APP_W-1:0]  app_wdf_data,
  output logic               app_wdf_rdy,
  output logic               app_rd_data_valid,
  output logic [`APP_W-1:0]  app_rd_data
);
  localparam int LINES  = 16;
  localparam int RD_LAT = 4;   // command acceptance to first read beat at the DUT

  logic [`APP_W-1:0]  mem_lo [LINES];       // first beat of each line
  logic [`APP_W-1:0]  mem_hi [LINES];
  int                 wr_count;             // completed write bursts
  logic [`ADDR_W-1:0] wr_addr_log [LINES];  // burst log, peeked at by the testbench
  logic [`APP_W-1:0]  wr_lo_log [LINES];
  logic [`APP_W-1:0]  wr_hi_log [LINES];
  logic [`ADDR_W-1:0] wr_addr;              // burst waiting for its second beat
  logic [`APP_W-1:0]  wr_lo;
  int                 rd_due [$];           // cycle at which each queued beat may go out
  logic [`APP_W-1:0]  rd_beat [$];
  int                 cyc;
  int                 slot;
  integer             seed;

  initial begin
    seed              = 95;
    cyc               = 0;
    wr_count          = 0;
    app_rdy           = 1'b0;
    app_wdf_rdy       = 1'b0;
    app_rd_data_valid = 1'b0;
    app_rd_data       = '0;
    forever begin
      @(posedge CLK or posedge fds_val);
      if (fds_val) begin
        app_rdy           = 1'b0;
        app_wdf_rdy       = 1'b0;
        app_rd_data_valid = 1'b0;
        wr_count          = 0;
        cyc               = 0;
        rd_due.delete();
        rd_beat.delete();
      end else begin
        cyc++;
        if (app_en && app_rdy) begin  // command accepted
          slot = int'(app_addr) / `ADDR_STEP % LINES;
          if (dram_read) begin
            rd_due.push_back(cyc + RD_LAT - 1);  // driven now, seen by the DUT next edge
            rd_beat.push_back(mem_lo[slot]);
            rd_due.push_back(cyc + RD_LAT);      // second beat right behind
            rd_beat.push_back(mem_hi[slot]);
          end else begin
            wr_addr      = app_addr;   // first beat rides with the write command
            wr_lo        = app_wdf_data;
            mem_lo[slot] = app_wdf_data;
          end
        end
        if (app_wdf_wren && app_wdf_end && app_wdf_rdy) begin  // closing beat
          slot         = int'(wr_addr) / `ADDR_STEP % LINES;
          mem_hi[slot] = app_wdf_data;
          if (wr_count < LINES) begin
            wr_addr_log[wr_count] = wr_addr;
            wr_lo_log[wr_count]   = wr_lo;
            wr_hi_log[wr_count]   = app_wdf_data;
          end
          wr_count++;
        end
        #1;
        app_rdy     = ($random(seed) % 4) != 0;  // ready about three cycles in four
        app_wdf_rdy = ($random(seed) % 4) != 0;
        if (rd_due.size() > 0 && rd_due[0] <= cyc) begin
          app_rd_data_valid = 1'b1;
          app_rd_data       = rd_beat.pop_front();
          void'(rd_due.pop_front());
        end else begin
          app_rd_data_valid = 1'b0;
        end
      end
    end
  end

endmodule

// File: logic/frame_app_top.sv
`timescale 1ns/1ps
`include "frame_app_macros.svh"

module frame_app_top (
  input  logic                    CLK,
  input  logic                    fds_val,
  input  logic                    pc_msg_pending,
  input  frame_app_pkg::xb_word_t pc_msg,
  output logic                    pc_msg_ack,
  output logic                    app_en,
  output logic                    dram_read,
  output logic [`ADDR_W-1:0]      app_addr,
  input  logic                    app_rdy,
  output logic                    app_wdf_wren,
  output logic                    app_wdf_end,
  output logic [`APP_W-1:0]       app_wdf_data,
  input  logic                    app_wdf_rdy,
  input  logic                    app_rd_data_valid,
  input  logic [`APP_W-1:0]       app_rd_data,
  output logic                    fpga_msg_valid,
  output logic [`APP_W-1:0]       fpga_msg,
  input  logic                    fpga_msg_full,
  output logic [`ROW_W-1:0]       n_row,
  output logic [`COL_W-1:0]       l_col,
  output logic [`FRAME_W-1:0]     n_frame,
  output logic                    error,
  output logic [3:0]              gpio_led
);
  frame_app_pkg::xb_word_t       msg_d, cf_word;
  frame_app_pkg::pixel_word_t    pix_din, pix_word;
  frame_app_pkg::loader_state_t  ld_state;
  logic pix_wren, pix_full, pix_empty, pix_pop, pix_ovf;
  logic cf_wren, cf_full, cf_empty, cf_pop, cf_ovf;
  logic frame_start, frame_idle, loader_error;

  assign pix_din  = frame_app_pkg::pixel_word_t'(msg_d); // same bits, pixel view
  assign error    = loader_error || pix_ovf;
  assign gpio_led = {ld_state, error};

  host_msg_splitter u_splitter (
    .CLK(CLK), .fds_val(fds_val), .pc_msg_pending(pc_msg_pending), .pc_msg(pc_msg),
    .pix_full(pix_full), .cf_full(cf_full), .pc_msg_ack(pc_msg_ack),
    .pix_wren(pix_wren), .cf_wren(cf_wren), .msg_d(msg_d));

  msg_fifo #(.payload_t(frame_app_pkg::pixel_word_t)) u_pix_fifo (
    .CLK(CLK), .fds_val(fds_val), .wr_en(pix_wren), .din(pix_din), .rd_en(pix_pop),
    .dout(pix_word), .empty(pix_empty), .full(pix_full), .overflow(pix_ovf));

  msg_fifo #(.payload_t(frame_app_pkg::xb_word_t)) u_cf_fifo (
    .CLK(CLK), .fds_val(fds_val), .wr_en(cf_wren), .din(msg_d), .rd_en(cf_pop),
    .dout(cf_word), .empty(cf_empty), .full(cf_full), .overflow(cf_ovf));

  pixel_timing u_pixel_timing (
    .CLK(CLK), .fds_val(fds_val), .pix_empty(pix_empty), .pix_word(pix_word),
    .pix_pop(pix_pop), .n_row(n_row), .l_col(l_col), .n_frame(n_frame),
    .frame_start(frame_start), .frame_idle(frame_idle));

  coeff_dram_ctrl u_coeff_ctrl (
    .CLK(CLK), .fds_val(fds_val), .cf_empty(cf_empty), .cf_word(cf_word),
    .app_rdy(app_rdy), .app_wdf_rdy(app_wdf_rdy), .app_rd_data_valid(app_rd_data_valid),
    .app_rd_data(app_rd_data), .fpga_msg_full(fpga_msg_full), .frame_start(frame_start),
    .fifo_overflow(cf_ovf || pix_ovf), .cf_pop(cf_pop), .app_en(app_en),
    .dram_read(dram_read), .app_addr(app_addr), .app_wdf_wren(app_wdf_wren),
    .app_wdf_end(app_wdf_end), .app_wdf_data(app_wdf_data),
    .fpga_msg_valid(fpga_msg_valid), .fpga_msg(fpga_msg), .state(ld_state),
    .loader_error(loader_error));

  // table replay only starts off the tracker's interframe gap
  // tracker leaves interframe, pulse next cycle, loader moves the cycle after
  a_replay_on_frame: assert property (@(posedge CLK) disable iff (fds_val)
    ($past(ld_state) == frame_app_pkg::LD_INTERFRAME
     && ld_state == frame_app_pkg::LD_READING) |-> $past(frame_idle, 2));

endmodule

// File: logic/coeff_dram_ctrl.sv
`timescale 1ns/1ps
`include "frame_app_macros.svh"

// packs coefficient words into DRAM lines, then streams the table back out
module coeff_dram_ctrl (
  input  logic                          CLK,
  input  logic                          fds_val,
  input  logic                          cf_empty,
  input  frame_app_pkg::xb_word_t       cf_word,
  input  logic                          app_rdy,
  input  logic                          app_wdf_rdy,
  input  logic                          app_rd_data_valid,
  input  logic [`APP_W-1:0]             app_rd_data,
  input  logic                          fpga_msg_full,
  input  logic                          frame_start,
  input  logic                          fifo_overflow,
  output logic                          cf_pop,
  output logic                          app_en,
  output logic                          dram_read,
  output logic [`ADDR_W-1:0]            app_addr,
  output logic                          app_wdf_wren,
  output logic                          app_wdf_end,
  output logic [`APP_W-1:0]             app_wdf_data,
  output logic                          fpga_msg_valid,
  output logic [`APP_W-1:0]             fpga_msg,
  output frame_app_pkg::loader_state_t  state,
  output logic                          loader_error
);
  localparam int WC_W = $clog2(`LINE_WORDS);
  localparam logic [WC_W-1:0]    LAST_WORD = WC_W'(`LINE_WORDS - 1);
  localparam logic [`ADDR_W-1:0] ADDR_INC  = `ADDR_W'(`ADDR_STEP);

  frame_app_pkg::dram_line_t line;   // words being packed
  logic [WC_W-1:0]    wcnt;          // next word slot in line
  logic [`ADDR_W-1:0] end_addr;      // one burst past the last written line
  logic [`ADDR_W-1:0] next_addr;
  logic               end_mark;      // line closes the table
  logic               cmd_req;       // command wanted, app_en qualifies it
  logic               cmd_accept;

  assign cf_pop       = (state == frame_app_pkg::LD_MSG_WAIT) && !cf_empty;
  // writes go out only with a beat slot free, reads hold off while the host side is full
  assign app_en       = cmd_req && (dram_read ? !fpga_msg_full : app_wdf_rdy);
  assign cmd_accept   = app_en && app_rdy;
  assign next_addr    = app_addr + ADDR_INC;
  assign loader_error = (state == frame_app_pkg::LD_ERROR);

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      state          <= frame_app_pkg::LD_MSG_WAIT;
      wcnt           <= '0;
      end_addr       <= '0;
      end_mark       <= 1'b0;
      cmd_req        <= 1'b0;
      dram_read      <= 1'b0;
      app_addr       <= '0;
      app_wdf_wren   <= 1'b0;
      app_wdf_end    <= 1'b1;
      fpga_msg_valid <= 1'b0;
    end else begin
      fpga_msg_valid <= app_rd_data_valid; // read beats pass straight through
      if (fifo_overflow) begin
        state        <= frame_app_pkg::LD_ERROR; // latched, only reset leaves
        cmd_req      <= 1'b0;
        app_wdf_wren <= 1'b0;
        app_wdf_end  <= 1'b1;
      end else begin
        case (state)
          frame_app_pkg::LD_MSG_WAIT: begin
            if (cf_pop) begin
              wcnt <= wcnt + 1'b1;  // wraps back to slot 0
              if (wcnt == LAST_WORD) begin
                end_mark     <= (cf_word[1:0] == 2'b01);
                end_addr     <= end_addr + ADDR_INC;
                cmd_req      <= 1'b1;
                app_wdf_wren <= 1'b1;  // first beat rides with the command
                app_wdf_end  <= 1'b0;
                state        <= frame_app_pkg::LD_WR_WAIT;
              end
            end
          end
          frame_app_pkg::LD_WR_WAIT: begin
            if (cmd_accept) begin
              cmd_req     <= 1'b0;
              app_addr    <= next_addr;
              app_wdf_end <= 1'b1;    // second beat is the last
              state       <= frame_app_pkg::LD_WR1;
            end
          end
          frame_app_pkg::LD_WR1: begin
            if (app_wdf_rdy) begin
              app_wdf_wren <= 1'b0;
              state        <= frame_app_pkg::LD_WR2;
            end
          end
          frame_app_pkg::LD_WR2: begin
            if (end_mark) begin
              app_addr  <= '0;      // replay from the table start
              dram_read <= 1'b1;
              cmd_req   <= 1'b1;
              state     <= frame_app_pkg::LD_READING;
            end else begin
              state <= frame_app_pkg::LD_MSG_WAIT;
            end
          end
          frame_app_pkg::LD_READING: begin
            if (cmd_accept) begin
              app_addr <= next_addr;
              if (next_addr == end_addr) begin
                cmd_req <= 1'b0;
                state   <= frame_app_pkg::LD_INTERFRAME;
              end
            end else if (fpga_msg_full) begin
              cmd_req <= 1'b0;  // reads in flight still come back
              state   <= frame_app_pkg::LD_THROTTLED;
            end
          end
          frame_app_pkg::LD_THROTTLED: begin
            if (!fpga_msg_full) begin
              cmd_req <= 1'b1;
              state   <= frame_app_pkg::LD_READING;
            end
          end
          frame_app_pkg::LD_INTERFRAME: begin
            if (frame_start) begin
              app_addr <= '0;
              cmd_req  <= 1'b1;
              state    <= frame_app_pkg::LD_READING;
            end
          end
          default: begin // error holds
          end
        endcase
      end
    end
  end

  // data path
  always_ff @(posedge CLK) begin
    fpga_msg <= app_rd_data;
    if (cf_pop) line[wcnt*`XB_W +: `XB_W] <= cf_word;
    if (cf_pop && wcnt == LAST_WORD) begin
      app_wdf_data <= line[0 +: `APP_W];        // words 0 and 1, already packed
    end else if (state == frame_app_pkg::LD_WR_WAIT && cmd_accept) begin
      app_wdf_data <= line[`APP_W +: `APP_W];   // words 2 and 3
    end
  end

  // idle write strobe always leaves end parked high
  a_end_idle: assert property (@(posedge CLK) disable iff (fds_val)
    !app_wdf_wren |-> app_wdf_end);

endmodule

// File: logic/pixel_timing.sv
`timescale 1ns/1ps
`include "frame_app_macros.svh"

// tracks frame, row and column from the fval/lval flags of each pixel word
module pixel_timing (
  input  logic                       CLK,
  input  logic                       fds_val,
  input  logic                       pix_empty,
  input  frame_app_pkg::pixel_word_t pix_word,
  output logic                       pix_pop,
  output logic [`ROW_W-1:0]          n_row,
  output logic [`COL_W-1:0]          l_col,
  output logic [`FRAME_W-1:0]        n_frame,
  output logic                       frame_start,
  output logic                       frame_idle
);
  localparam logic [`COL_W-1:0] COL_STEP = `COL_W'(`PIX_PER_CLK);

  frame_app_pkg::pixel_state_t state;
  logic fval, lval;

  assign pix_pop    = !pix_empty;   // pixels never wait, pop whatever is there
  assign fval       = pix_word.fval;
  assign lval       = pix_word.lval;
  assign frame_idle = (state == frame_app_pkg::PIX_INTERFRAME);

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      state       <= frame_app_pkg::PIX_STANDBY;
      n_row       <= '0;
      l_col       <= '0;
      n_frame     <= '0;
      frame_start <= 1'b0;
    end else begin
      frame_start <= 1'b0; // single cycle pulse
      if (pix_pop) begin
        case (state)
          frame_app_pkg::PIX_STANDBY: begin
            // sync on a gap between frames before counting anything
            if (!fval) begin
              n_row   <= '0;
              l_col   <= '0;
              n_frame <= '0;
              state   <= frame_app_pkg::PIX_INTERFRAME;
            end
          end
          frame_app_pkg::PIX_INTRALINE: begin
            if (lval) begin
              l_col <= l_col + COL_STEP;
            end else if (fval) begin
              n_row <= n_row + 1'b1;     // line done, frame goes on
              state <= frame_app_pkg::PIX_INTERLINE;
            end else begin
              n_frame <= n_frame + 1'b1; // line and frame end together
              state   <= frame_app_pkg::PIX_INTERFRAME;
            end
          end
          frame_app_pkg::PIX_INTERLINE: begin
            if (lval) begin
              l_col <= COL_STEP;  // column restarts, this word already counts
              state <= frame_app_pkg::PIX_INTRALINE;
            end
          end
          default: begin // interframe
            if (lval) begin
              l_col       <= COL_STEP;
              n_row       <= '0;
              frame_start <= 1'b1;  // loader replays its table on this
              state       <= frame_app_pkg::PIX_INTRALINE;
            end
          end
        endcase
      end
    end
  end

endmodule

// File: logic/host_msg_splitter.sv
`timescale 1ns/1ps

// takes words off the host port and steers them to the pixel or coefficient FIFO
module host_msg_splitter (
  input  logic                    CLK,
  input  logic                    fds_val,
  input  logic                    pc_msg_pending,
  input  frame_app_pkg::xb_word_t pc_msg,
  input  logic                    pix_full,
  input  logic                    cf_full,
  output logic                    pc_msg_ack,
  output logic                    pix_wren,
  output logic                    cf_wren,
  output frame_app_pkg::xb_word_t msg_d
);
  logic [3:0] n_cf;   // coefficient words seen, wraps every 16
  logic       is_pix;

  // take a word only when both FIFOs have room
  assign pc_msg_ack = pc_msg_pending && !pix_full && !cf_full;

  // once a coefficient run starts, the next 15 words follow it whatever their tag
  assign is_pix = (pc_msg[1:0] == 2'b00) && (n_cf == 4'd0);

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      n_cf     <= 4'd0;
      pix_wren <= 1'b0;
      cf_wren  <= 1'b0;
    end else begin
      pix_wren <= pc_msg_ack && is_pix;  // FIFO write lands a cycle after ack
      cf_wren  <= pc_msg_ack && !is_pix;
      if (pc_msg_ack && !is_pix) n_cf <= n_cf + 4'd1;
    end
  end

  // word lines up with the registered write enables
  always_ff @(posedge CLK) begin
    if (pc_msg_ack) msg_d <= pc_msg;
  end

  a_one_dest: assert property (@(posedge CLK) disable iff (fds_val)
    !(pix_wren && cf_wren));

endmodule

// File: logic/msg_fifo.sv
`timescale 1ns/1ps
`include "frame_app_macros.svh"

// circular buffer, head word always visible on dout
module msg_fifo #(
  parameter type payload_t = frame_app_pkg::xb_word_t,
  parameter int  DEPTH     = `FIFO_DEPTH
) (
  input  logic     CLK,
  input  logic     fds_val,
  input  logic     wr_en,
  input  payload_t din,
  input  logic     rd_en,
  output payload_t dout,
  output logic     empty,
  output logic     full,
  output logic     overflow
);
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;   // one bit wider than the pointers
  logic             do_wr, do_rd;

  assign do_wr = wr_en && !full;  // write while full is dropped
  assign do_rd = rd_en && !empty;
  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));
  assign dout  = mem[rd_ptr];     // fall-through head

  always_ff @(posedge CLK) begin
    if (do_wr) mem[wr_ptr] <= din;
  end

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_wr) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // none, or both at once
      endcase
      if (wr_en && full) overflow <= 1'b1; // sticky until reset
    end
  end

  // the consumer must look at empty before popping
  a_no_read_empty: assert property (@(posedge CLK) disable iff (fds_val)
    rd_en |-> !empty);

endmodule

// File: logic/frame_app_pkg.sv
`include "frame_app_macros.svh"

package frame_app_pkg;

  typedef logic [`XB_W-1:0] xb_word_t; // raw host word

  // host word seen as a pixel message, only the two flags are decoded here
  typedef struct packed {
    logic [`XB_W-1:6] payload_hi;
    logic             fval;       // frame valid, bit 5
    logic             lval;       // line valid, bit 4
    logic [3:0]       payload_lo;
  } pixel_word_t;

  typedef logic [`LINE_WORDS*`XB_W-1:0] dram_line_t; // word 0 in the low bits

  // coefficient loader, encoding also shows on the LEDs
  typedef enum logic [2:0] {
    LD_ERROR      = 3'd0,
    LD_WR1        = 3'd1, // second beat offered
    LD_WR2        = 3'd2, // burst done, pick next step
    LD_MSG_WAIT   = 3'd3, // collecting host words
    LD_WR_WAIT    = 3'd4, // command plus first beat offered
    LD_READING    = 3'd5,
    LD_THROTTLED  = 3'd6,
    LD_INTERFRAME = 3'd7
  } loader_state_t;

  typedef enum logic [1:0] {
    PIX_STANDBY,
    PIX_INTRALINE,
    PIX_INTERLINE,
    PIX_INTERFRAME
  } pixel_state_t;

endpackage

// File: include/frame_app_macros.svh
`ifndef FRAME_APP_MACROS_SVH
`define FRAME_APP_MACROS_SVH

// host message port
`define XB_W 32          // host word width

// DRAM side
`define APP_W 64         // one data beat
`define LINE_WORDS 4     // host words per DRAM line, two beats
`define ADDR_W 27
`define ADDR_STEP 8      // address advance per two-beat burst

`define FIFO_DEPTH 16    // each message FIFO

// pixel tracker counters
`define COL_W 11
`define ROW_W 12
`define FRAME_W 20
`define PIX_PER_CLK 2    // pixels carried by one pixel word

`endif
